//--- src/clk_ctrl_pkg.sv
`default_nettype none

package clk_ctrl_pkg;

	// ------------------------------------------------------------------------
	// Sizes and timing constants
	// ------------------------------------------------------------------------
	localparam int CMP_STEPS     = 32;   // Comparator phase codes per clock cycle
	localparam int CMP_PHASE_W   = 11;   // Fine phase, 1344 steps per 25 ns
	localparam int RST_PIPE_LEN  = 8;
	localparam int HOLDOFF_US    = 100;  // Data-stream resync blocked for 100 us
	localparam int TICK_DIV      = 40;   // 40 MHz down to 1 us ticks
	localparam int SETTLE_CYCLES = 3;

	// ------------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------------
	typedef logic [$clog2(CMP_STEPS)-1:0] cmp_code_t;
	typedef logic [CMP_PHASE_W-1:0]       cmp_phase_t;
	typedef logic [2:0]                   samp_phase_t;  // Bit 2 picks the 20 MHz edge
	typedef logic [RST_PIPE_LEN-1:0]      rst_pipe_t;
	typedef logic [7:0]                   holdoff_cnt_t;
	typedef logic [5:0]                   tick_cnt_t;

	// Dynamic phase shift FSM states
	typedef enum logic [2:0] {
		PS_IDLE      = 3'd0,
		PS_WAIT_LOCK = 3'd1,
		PS_REQ       = 3'd2,
		PS_WAIT_DONE = 3'd3,
		PS_SETTLE    = 3'd4
	} phs_state_e;

endpackage

`default_nettype wire

//--- src/resync_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module resync_sequencer import clk_ctrl_pkg::*; (
	input  wire              CLK40,
	input  wire              RST,
	input  wire              resync_i,
	input  wire              samp_clk_phs_chng_i,
	input  wire samp_phase_t samp_clk_phase_i,
	output logic             lead_edg_resync_o,
	output logic             cap_phase_o,
	output logic             rst_samp_mmcm_o,
	output logic             samp_in_sel_o
);

	logic      rst_d1;
	logic      rst_d2;
	logic      resync_d1;
	logic      lead_edg_d1;
	logic      trl_edg_rst;
	logic      pipe_in;
	rst_pipe_t rst_pipe;
	logic      clk20_phase;
	logic      c20_phase_sel;

	// ------------------------------------------------------------------------
	// Edge detection and capture pulse
	// ------------------------------------------------------------------------

	// Follows RST so the release can be seen
	always_ff @(posedge CLK40) begin
		rst_d1 <= RST;
		rst_d2 <= rst_d1;
	end

	assign trl_edg_rst       = ~RST & rst_d2;         // Two cycles wide
	assign lead_edg_resync_o = resync_i & ~resync_d1; // One cycle wide

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			resync_d1   <= 1'b0;
			lead_edg_d1 <= 1'b0;
			cap_phase_o <= 1'b0;
		end else begin
			resync_d1   <= resync_i;
			lead_edg_d1 <= lead_edg_resync_o;
			// Two cycles wide for a resync edge
			cap_phase_o <= lead_edg_resync_o | lead_edg_d1 | trl_edg_rst | samp_clk_phs_chng_i;
		end
	end

	// ------------------------------------------------------------------------
	// Sample MMCM reset stretcher
	// ------------------------------------------------------------------------
	assign pipe_in = lead_edg_resync_o | trl_edg_rst | cap_phase_o | samp_clk_phs_chng_i;

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			rst_pipe <= '0;
		else
			rst_pipe <= {rst_pipe[RST_PIPE_LEN-2:0], pipe_in};
	end

	assign rst_samp_mmcm_o = |rst_pipe;

	// 20 MHz phase, aligned to resync
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			clk20_phase   <= 1'b0;
			c20_phase_sel <= 1'b0;
		end else begin
			clk20_phase <= lead_edg_resync_o ? 1'b0 : ~clk20_phase;
			if (cap_phase_o)
				c20_phase_sel <= clk20_phase;  // Held until next capture
		end
	end

	assign samp_in_sel_o = samp_clk_phase_i[2] ^ c20_phase_sel;

	// MMCM must already be in reset while the new phase is taken
	a_cap_in_reset: assert property (@(posedge CLK40) disable iff (RST)
		cap_phase_o |=> rst_samp_mmcm_o);

endmodule

`default_nettype wire

//--- src/dsr_holdoff.sv
`timescale 1ns/1ps
`default_nettype none

module dsr_holdoff import clk_ctrl_pkg::*; (
	input  wire  CLK40,
	input  wire  RST,
	input  wire  cap_phase_i,
	output logic dsr_resync_o
);

	tick_cnt_t    tick_cnt;
	logic         us_tick;
	holdoff_cnt_t us_cnt;
	logic         clr_holdoff;

	// ------------------------------------------------------------------------
	// 1 us tick prescaler, free running
	// ------------------------------------------------------------------------
	assign us_tick = (tick_cnt == tick_cnt_t'(TICK_DIV - 1));

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			tick_cnt <= '0;
		else if (us_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// ------------------------------------------------------------------------
	// Holdoff flag and microsecond timer
	// ------------------------------------------------------------------------
	assign clr_holdoff = (us_cnt == holdoff_cnt_t'(HOLDOFF_US));  // 100 us done

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			dsr_resync_o <= 1'b0;
			us_cnt       <= '0;
		end else begin
			if (cap_phase_i)
				dsr_resync_o <= 1'b1;
			else if (clr_holdoff)
				dsr_resync_o <= 1'b0;

			// New capture restarts the window
			if (cap_phase_i || !dsr_resync_o)
				us_cnt <= '0;
			else if (us_tick)
				us_cnt <= us_cnt + 1'b1;
		end
	end

	// Flag must drop before the timer can run past the limit
	a_cnt_limit: assert property (@(posedge CLK40) disable iff (RST)
		us_cnt <= holdoff_cnt_t'(HOLDOFF_US));

endmodule

`default_nettype wire

//--- src/cmp_phase_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_phase_tracker import clk_ctrl_pkg::*; (
	input  wire            CLK40,
	input  wire            cmp_rst_i,
	input  wire cmp_code_t cmp_clk_phase_i,
	input  wire            psen_i,
	output cmp_phase_t     cmp_phase_o,
	output logic           cmp_phs_incdec_o,
	output logic           cmp_phs_change_o
);

	cmp_phase_t cmp_rom [CMP_STEPS];
	cmp_phase_t cur_phase;  // Phase presumed inside the MMCM
	logic       chg_m1;

	// ------------------------------------------------------------------------
	// Code to fine step table
	// 32 codes per 25 ns mapped onto 1344 MMCM steps
	// ------------------------------------------------------------------------
	initial begin
		$readmemh("src/comp_phase.hex", cmp_rom);
	end

	always_ff @(posedge CLK40) begin
		cmp_phase_o      <= cmp_rom[cmp_clk_phase_i];
		cmp_phs_incdec_o <= (cmp_phase_o > cur_phase);  // High to step up
	end

	// Change flag, one extra stage so a step can settle
	always_ff @(posedge CLK40 or posedge cmp_rst_i) begin
		if (cmp_rst_i) begin
			chg_m1           <= 1'b0;
			cmp_phs_change_o <= 1'b0;
		end else begin
			chg_m1           <= (cmp_phase_o != cur_phase);
			cmp_phs_change_o <= chg_m1;
		end
	end

	// ------------------------------------------------------------------------
	// Presumed MMCM phase
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge cmp_rst_i) begin
		if (cmp_rst_i)
			cur_phase <= '0;  // MMCM comes out of reset at phase 0
		else if (psen_i) begin
			if (cmp_phs_incdec_o)
				cur_phase <= cur_phase + 1'b1;
			else
				cur_phase <= cur_phase - 1'b1;
		end
	end

	// A step request should never push the count past either end
	a_no_wrap: assert property (@(posedge CLK40) disable iff (cmp_rst_i)
		psen_i |-> (cmp_phs_incdec_o ? (cur_phase != '1) : (cur_phase != '0)));

endmodule

`default_nettype wire

//--- src/dyn_phase_shift_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dyn_phase_shift_fsm import clk_ctrl_pkg::*; (
	input  wire  CLK40,
	input  wire  cmp_rst_i,
	input  wire  lock_i,
	input  wire  change_i,
	input  wire  psdone_i,
	output logic psen_o,
	output logic busy_o,
	output phs_state_e state_o
);

	phs_state_e state;
	phs_state_e next_state;
	logic [1:0] settle_cnt;

	// ------------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			PS_IDLE: begin
				if (change_i)
					next_state = PS_WAIT_LOCK;
			end
			PS_WAIT_LOCK: begin
				if (lock_i)
					next_state = PS_REQ;
			end
			PS_REQ: begin
				next_state = PS_WAIT_DONE;  // Single psen cycle
			end
			PS_WAIT_DONE: begin
				if (psdone_i)
					next_state = PS_SETTLE;
			end
			PS_SETTLE: begin
				// Change flag lags the step, look only after settling
				if (settle_cnt == 2'd0)
					next_state = change_i ? PS_WAIT_LOCK : PS_IDLE;
			end
			default: begin
				next_state = PS_IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// State, settle counter and request
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge cmp_rst_i) begin
		if (cmp_rst_i) begin
			state      <= PS_IDLE;
			settle_cnt <= 2'd0;
			psen_o     <= 1'b0;
		end else begin
			state  <= next_state;
			psen_o <= (next_state == PS_REQ);

			if (state == PS_WAIT_DONE && psdone_i)
				settle_cnt <= 2'(SETTLE_CYCLES - 1);
			else if (state == PS_SETTLE && settle_cnt != 2'd0)
				settle_cnt <= settle_cnt - 2'd1;
		end
	end

	assign busy_o  = (state != PS_IDLE);
	assign state_o = state;

	// Request register must stay in step with the state register
	a_psen_in_req: assert property (@(posedge CLK40) disable iff (cmp_rst_i)
		psen_o |-> (state == PS_REQ));

endmodule

`default_nettype wire

//--- src/clock_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_top import clk_ctrl_pkg::*; (
	input  wire              CLK40,
	input  wire              RST,
	input  wire              resync_i,
	input  wire              samp_clk_phs_chng_i,
	input  wire samp_phase_t samp_clk_phase_i,
	input  wire cmp_code_t   cmp_clk_phase_i,
	input  wire              cmp_phs_jtag_rst_i,
	input  wire              trg_mmcm_lock_i,
	input  wire              cmp_phs_psdone_i,
	output logic             lead_edg_resync_o,
	output logic             cap_phase_o,
	output logic             rst_samp_mmcm_o,
	output logic             samp_in_sel_o,
	output logic             dsr_resync_o,
	output cmp_phase_t       cmp_phase_o,
	output logic             cmp_phs_psen_o,
	output logic             cmp_phs_incdec_o,
	output logic             cmp_phs_change_o,
	output logic             cmp_phs_busy_o,
	output phs_state_e       cmp_phs_state_o,
	output logic             cmp_phs_rst_o
);

	logic cmp_rst;
	logic cap_phase;
	logic cmp_phs_change;
	logic cmp_phs_psen;

	// Comparator MMCM reset, board reset or JTAG request
	assign cmp_rst       = RST | cmp_phs_jtag_rst_i;
	assign cmp_phs_rst_o = cmp_rst;

	// ------------------------------------------------------------------------
	// Sample clock side
	// ------------------------------------------------------------------------
	resync_sequencer i_resync_seq (
		.CLK40               (CLK40),
		.RST                 (RST),
		.resync_i            (resync_i),
		.samp_clk_phs_chng_i (samp_clk_phs_chng_i),
		.samp_clk_phase_i    (samp_clk_phase_i),
		.lead_edg_resync_o   (lead_edg_resync_o),
		.cap_phase_o         (cap_phase),
		.rst_samp_mmcm_o     (rst_samp_mmcm_o),
		.samp_in_sel_o       (samp_in_sel_o)
	);

	assign cap_phase_o = cap_phase;

	dsr_holdoff i_dsr_holdoff (
		.CLK40        (CLK40),
		.RST          (RST),
		.cap_phase_i  (cap_phase),
		.dsr_resync_o (dsr_resync_o)
	);

	// ------------------------------------------------------------------------
	// Comparator clock phase stepping
	// ------------------------------------------------------------------------
	cmp_phase_tracker i_cmp_tracker (
		.CLK40            (CLK40),
		.cmp_rst_i        (cmp_rst),
		.cmp_clk_phase_i  (cmp_clk_phase_i),
		.psen_i           (cmp_phs_psen),
		.cmp_phase_o      (cmp_phase_o),
		.cmp_phs_incdec_o (cmp_phs_incdec_o),
		.cmp_phs_change_o (cmp_phs_change)
	);

	dyn_phase_shift_fsm i_phs_fsm (
		.CLK40     (CLK40),
		.cmp_rst_i (cmp_rst),
		.lock_i    (trg_mmcm_lock_i),
		.change_i  (cmp_phs_change),
		.psdone_i  (cmp_phs_psdone_i),
		.psen_o    (cmp_phs_psen),
		.busy_o    (cmp_phs_busy_o),
		.state_o   (cmp_phs_state_o)
	);

	assign cmp_phs_change_o = cmp_phs_change;
	assign cmp_phs_psen_o   = cmp_phs_psen;  // Straight to the MMCM PSEN pin

endmodule

`default_nettype wire

//--- bench/clock_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_tb import clk_ctrl_pkg::*; ;

	logic        CLK40;
	logic        RST;
	logic        resync;
	logic        samp_chng;
	samp_phase_t samp_phase;
	cmp_code_t   cmp_code;
	logic        jtag_rst;
	logic        lock;
	logic        psdone;

	logic        lead_edg;
	logic        cap_phase;
	logic        rst_samp;
	logic        samp_in_sel;
	logic        dsr_resync;
	cmp_phase_t  cmp_phase;
	logic        psen;
	logic        incdec;
	logic        change;
	logic        busy;
	phs_state_e  state;
	logic        cmp_rst;

	int          err_cnt = 0;
	int          timeout_cnt = 0;
	int unsigned rnd_state = 50387;
	int          model_phase = 0;  // Phase the MMCM model really has
	int          psen_cnt = 0;
	int          done_cnt = 0;
	int          lock_cnt = 0;

	clock_ctrl_top i_dut (
		.CLK40               (CLK40),
		.RST                 (RST),
		.resync_i            (resync),
		.samp_clk_phs_chng_i (samp_chng),
		.samp_clk_phase_i    (samp_phase),
		.cmp_clk_phase_i     (cmp_code),
		.cmp_phs_jtag_rst_i  (jtag_rst),
		.trg_mmcm_lock_i     (lock),
		.cmp_phs_psdone_i    (psdone),
		.lead_edg_resync_o   (lead_edg),
		.cap_phase_o         (cap_phase),
		.rst_samp_mmcm_o     (rst_samp),
		.samp_in_sel_o       (samp_in_sel),
		.dsr_resync_o        (dsr_resync),
		.cmp_phase_o         (cmp_phase),
		.cmp_phs_psen_o      (psen),
		.cmp_phs_incdec_o    (incdec),
		.cmp_phs_change_o    (change),
		.cmp_phs_busy_o      (busy),
		.cmp_phs_state_o     (state),
		.cmp_phs_rst_o       (cmp_rst)
	);

	initial begin
		CLK40 = 1'b0;
		forever #5 CLK40 = ~CLK40;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic int next_random();
		rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
		return int'(rnd_state[30:16]);
	endfunction

	// Nearest integer to code * 1344 / 31
	function automatic int cmp_ref(input int code);
		return (code * 2688 + 31) / 62;
	endfunction

	function automatic int distance(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic bit sig_val(input int sel);
		case (sel)
			0: return rst_samp;
			1: return cap_phase;
			2: return dsr_resync;
			3: return busy;
			default: return !busy && !change;  // Walk finished
		endcase
	endfunction

	task automatic check_eq(input string what, input int got, input int exp);
		if (got != exp) begin
			err_cnt++;
			$display("ERROR at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic wait_level(input int sel, input bit level, input int limit,
			input string what);
		int  n;
		bit  hit;
		n   = 0;
		hit = 1'b0;
		while (!hit && n < limit) begin
			@(negedge CLK40);
			hit = (sig_val(sel) == level);
			n++;
		end
		if (!hit) begin
			timeout_cnt++;
			$display("Timed out at %0d ns while waiting for %s", $time, what);
		end
	endtask

	// ------------------------------------------------------------------------
	// MMCM dynamic phase shift model
	// ------------------------------------------------------------------------
	always @(posedge CLK40) begin
		bit rst_seen;
		bit psen_seen;
		bit up;
		rst_seen  = cmp_rst;
		psen_seen = psen;
		up        = incdec;
		#1;
		if (rst_seen) begin
			lock        = 1'b0;
			psdone      = 1'b0;
			lock_cnt    = 0;
			done_cnt    = 0;
			model_phase = 0;
			psen_cnt    = 0;
		end else begin
			if (psen_seen) begin
				check_eq("lock high at psen", int'(lock), 1);
				check_eq("psen while psdone pending", int'(done_cnt > 0 || psdone), 0);
			end
			psdone = 1'b0;
			if (done_cnt > 0) begin
				done_cnt--;
				if (done_cnt == 0)
					psdone = 1'b1;
			end
			if (psen_seen) begin
				done_cnt    = 1 + next_random() % 4;
				model_phase = up ? model_phase + 1 : model_phase - 1;
				psen_cnt++;
			end
			if (lock_cnt < 20)
				lock_cnt++;
			lock = (lock_cnt >= 20);
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus and checks
	// ------------------------------------------------------------------------
	initial begin
		int cnt_lead;
		int cnt_cap;
		int cnt_rst;
		int rst_runs;
		bit prev_rst;
		int since_cap;
		int old_sel;
		int code;
		int exp_ref;
		int prev_ref;
		int psen_start;
		RST        = 1'b1;
		resync     = 1'b0;
		samp_chng  = 1'b0;
		samp_phase = '0;
		cmp_code   = '0;
		jtag_rst   = 1'b0;
		lock       = 1'b0;
		psdone     = 1'b0;
		repeat (7) @(posedge CLK40);

		// Outputs held low while in reset
		@(negedge CLK40);
		check_eq("MMCM reset during reset", int'(rst_samp), 0);
		check_eq("holdoff during reset", int'(dsr_resync), 0);
		check_eq("psen during reset", int'(psen), 0);
		check_eq("busy during reset", int'(busy), 0);
		check_eq("state during reset", int'(state), int'(PS_IDLE));
		@(posedge CLK40);
		#1 RST = 1'b0;

		// Reset release and phase change pulse
		wait_level(0, 1'b1, 5, "MMCM reset after reset release");
		wait_level(1, 1'b1, 5, "capture after reset release");
		wait_level(2, 1'b1, 5, "holdoff after reset release");
		wait_level(0, 1'b0, 30, "end of MMCM reset");
		@(posedge CLK40);
		#1 samp_chng = 1'b1;
		@(posedge CLK40);
		#1 samp_chng = 1'b0;
		@(negedge CLK40);
		check_eq("MMCM reset after phase change", int'(rst_samp), 1);
		wait_level(0, 1'b0, 30, "end of MMCM reset");

		// Isolated resync edge
		cnt_lead = 0;
		cnt_cap  = 0;
		cnt_rst  = 0;
		rst_runs = 0;
		prev_rst = 1'b0;
		@(posedge CLK40);
		#1 resync = 1'b1;
		repeat (24) begin
			@(negedge CLK40);
			cnt_lead += int'(lead_edg);
			cnt_cap  += int'(cap_phase);
			cnt_rst  += int'(rst_samp);
			if (rst_samp && !prev_rst)
				rst_runs++;
			prev_rst = rst_samp;
		end
		check_eq("resync edge cycles", cnt_lead, 1);
		check_eq("capture cycles", cnt_cap, 2);
		check_eq("MMCM reset cycles", cnt_rst, 10);
		check_eq("MMCM reset pulses", rst_runs, 1);

		// Sample input select follows bit 2
		old_sel = int'(samp_in_sel);
		@(posedge CLK40);
		#1 samp_phase = 3'b100;
		@(negedge CLK40);
		check_eq("input select after bit 2 set", int'(samp_in_sel), 1 - old_sel);
		@(posedge CLK40);
		#1 samp_phase = 3'b011;
		@(negedge CLK40);
		check_eq("input select after bit 2 clear", int'(samp_in_sel), old_sel);

		// Holdoff restarted by a second resync
		repeat (1000) @(negedge CLK40);
		check_eq("holdoff active before restart", int'(dsr_resync), 1);
		@(posedge CLK40);
		#1 resync = 1'b0;
		@(posedge CLK40);
		#1 resync = 1'b1;
		since_cap = 0;
		wait_level(1, 1'b1, 5, "capture from second resync");
		while (dsr_resync && since_cap < 5000) begin
			@(negedge CLK40);
			since_cap = cap_phase ? 0 : since_cap + 1;
		end
		check_eq("holdoff length in range",
			int'(since_cap >= 3961 && since_cap <= 4041), 1);
		$display("Holdoff ended %0d cycles after the last capture", since_cap);

		// Comparator phase walks
		prev_ref = 0;
		code     = 0;
		for (int i = 0; i < 6; i++) begin
			code       = next_random() % 32;
			exp_ref    = cmp_ref(code);
			psen_start = psen_cnt;
			@(posedge CLK40);
			#1 cmp_code = cmp_code_t'(code);
			repeat (2) @(negedge CLK40);
			check_eq("table phase", int'(cmp_phase), exp_ref);
			repeat (4) @(negedge CLK40);
			wait_level(4, 1'b1, 30000, "phase walk to finish");
			check_eq("model phase after walk", model_phase, exp_ref);
			check_eq("psen pulses", psen_cnt - psen_start, distance(exp_ref, prev_ref));
			prev_ref = exp_ref;
		end

		// JTAG reset in the middle of a walk
		code = (code + 16) % 32;
		if (code == 0)
			code = 16;
		exp_ref = cmp_ref(code);
		@(posedge CLK40);
		#1 cmp_code = cmp_code_t'(code);
		wait_level(3, 1'b1, 20, "busy after new code");
		repeat (100) @(posedge CLK40);
		#1 jtag_rst = 1'b1;
		@(negedge CLK40);
		check_eq("state in JTAG reset", int'(state), int'(PS_IDLE));
		check_eq("comparator reset output", int'(cmp_rst), 1);
		@(posedge CLK40);
		#1 jtag_rst = 1'b0;
		@(negedge CLK40);
		psen_start = psen_cnt;
		repeat (6) @(negedge CLK40);
		check_eq("waiting for lock after JTAG reset", int'(state), int'(PS_WAIT_LOCK));
		wait_level(4, 1'b1, 30000, "phase walk after JTAG reset");
		check_eq("model phase after restart", model_phase, exp_ref);
		check_eq("psen pulses after restart", psen_cnt - psen_start, exp_ref);

		$display("Mismatches: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/comp_phase.hex
000
02B
057
082
0AD
0D9
104
12F
15B
186
1B2
1DD
208
234
25F
28A
2B6
2E1
30C
338
363
38E
3BA
3E5
411
43C
467
493
4BE
4E9
515
540

//--- src.f
src/clk_ctrl_pkg.sv
src/resync_sequencer.sv
src/dsr_holdoff.sv
src/cmp_phase_tracker.sv
src/dyn_phase_shift_fsm.sv
src/clock_ctrl_top.sv
bench/clock_ctrl_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the clock control testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module clock_ctrl_tb \
	-o clock_ctrl_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/clock_ctrl_sim > sim.log 2>&1 \
	|| echo "Simulation exited with an error status"

grep -qx "all tests passed" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, see sim.log"; exit 1; }
